//--- include/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// width of every datapath word.
`define MIPS_DATA_WIDTH 32

// a register address selects one of the architectural registers.
`define MIPS_REG_ADDR_WIDTH 5
`define MIPS_REG_COUNT 32

`endif

//--- source/mips_isa_pkg.sv
`default_nettype none
`include "mips_macros.svh"

package mips_isa_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0a,
		OP_ORI   = 6'h0d,
		OP_SW    = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		FUNCT_MFHI = 6'h10,
		FUNCT_MFLO = 6'h12,
		FUNCT_MULT = 6'h18,
		FUNCT_ADDU = 6'h21,
		FUNCT_SUBU = 6'h23,
		FUNCT_AND  = 6'h24,
		FUNCT_OR   = 6'h25,
		FUNCT_SLT  = 6'h2a
	} funct_t;

	// the alu code reuses the funct encoding, so r-type decode is a plain cast.
	typedef enum logic [5:0] {
		ALU_NOP  = 6'h00,
		ALU_MFHI = 6'h10,
		ALU_MFLO = 6'h12,
		ALU_MULT = 6'h18,
		ALU_ADDU = 6'h21,
		ALU_SUBU = 6'h23,
		ALU_AND  = 6'h24,
		ALU_OR   = 6'h25,
		ALU_SLT  = 6'h2a
	} alu_function_t;

	typedef enum logic [1:0] {
		SRC_B_REGISTER,
		SRC_B_SIGN_IMMEDIATE,
		SRC_B_ZERO_IMMEDIATE
	} alu_src_b_t;

	typedef enum logic [1:0] {
		DEST_RT,
		DEST_RD,
		DEST_RA
	} register_destination_t;

	typedef struct packed {
		logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
		logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
		logic [`MIPS_REG_ADDR_WIDTH-1:0] rd;
		logic [4:0] shamt;
		funct_t funct;
	} register_fields_t;

	typedef struct packed {
		logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
		logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
		logic [15:0] immediate;
	} immediate_fields_t;

	// all three layouts cover the 26 bits below the opcode.
	typedef union packed {
		register_fields_t r;
		immediate_fields_t i;
		logic [25:0] index;
	} operand_fields_t;

	typedef struct packed {
		opcode_t opcode;
		operand_fields_t fields;
	} instruction_t;

endpackage

`default_nettype wire

//--- source/mips_pipeline_pkg.sv
`default_nettype none
`include "mips_macros.svh"

package mips_pipeline_pkg;

	import mips_isa_pkg::*;

	typedef struct packed {
		logic register_write;
		logic memory_to_register;
		logic memory_write;
		alu_src_b_t alu_src_b;
		register_destination_t register_destination;
		logic hi_register_write;
		logic lo_register_write;
		alu_function_t alu_function;
		logic program_counter_multiplexer_jump;
		logic j_instruction;
		logic using_hi_lo;
	} control_t;

	////////////////////////////////////////////////////
	// stage payloads.
	////////////////////////////////////////////////////

	typedef struct packed {
		control_t control;
		logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
		logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
		logic [`MIPS_REG_ADDR_WIDTH-1:0] rd;
		logic [`MIPS_DATA_WIDTH-1:0] sign_imm;
		logic [`MIPS_DATA_WIDTH-1:0] src_a;
		logic [`MIPS_DATA_WIDTH-1:0] src_b;
		logic [`MIPS_DATA_WIDTH-1:0] program_counter_plus_four;
		logic [`MIPS_DATA_WIDTH-1:0] j_program_counter;
	} decode_execute_t;

	// the store fields ride along with the register result. memory_write qualifies them.
	typedef struct packed {
		logic register_write;
		logic [`MIPS_REG_ADDR_WIDTH-1:0] write_register;
		logic [`MIPS_DATA_WIDTH-1:0] result;
		logic memory_write;
		logic [`MIPS_DATA_WIDTH-1:0] store_data;
		logic [`MIPS_DATA_WIDTH-1:0] memory_address;
	} execute_writeback_t;

endpackage

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module register_file (
	input  logic clk,
	input  logic reset,
	input  logic [`MIPS_REG_ADDR_WIDTH-1:0] read_address_a,
	input  logic [`MIPS_REG_ADDR_WIDTH-1:0] read_address_b,
	output logic [`MIPS_DATA_WIDTH-1:0] read_data_a,
	output logic [`MIPS_DATA_WIDTH-1:0] read_data_b,
	input  logic write_enable,
	input  logic [`MIPS_REG_ADDR_WIDTH-1:0] write_address,
	input  logic [`MIPS_DATA_WIDTH-1:0] write_data
);

	logic [`MIPS_DATA_WIDTH-1:0] registers [`MIPS_REG_COUNT];
	logic write_active;

	assign write_active = write_enable && (write_address != '0);

	// a read of the register being written sees the new value in the same cycle.
	function automatic logic [`MIPS_DATA_WIDTH-1:0] read_port(
		input logic [`MIPS_REG_ADDR_WIDTH-1:0] address
	);
		if (write_active && (address == write_address))
			return write_data;
		return registers[address];
	endfunction

	always_comb begin
		read_data_a = read_port(read_address_a);
		read_data_b = read_port(read_address_b);
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++)
				registers[i] <= '0;
		end else if (write_active) begin
			registers[write_address] <= write_data;
		end
	end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module decode_stage (
	input  mips_isa_pkg::instruction_t instruction,
	input  logic [`MIPS_DATA_WIDTH-1:0] instruction_program_counter,
	input  logic instruction_valid,
	output logic [`MIPS_REG_ADDR_WIDTH-1:0] read_address_a,
	output logic [`MIPS_REG_ADDR_WIDTH-1:0] read_address_b,
	input  logic [`MIPS_DATA_WIDTH-1:0] read_data_a,
	input  logic [`MIPS_DATA_WIDTH-1:0] read_data_b,
	output mips_pipeline_pkg::decode_execute_t decoded
);

	import mips_isa_pkg::*;
	import mips_pipeline_pkg::*;

	control_t control;
	logic [`MIPS_DATA_WIDTH-1:0] program_counter_plus_four;

	assign read_address_a = instruction.fields.r.rs;
	assign read_address_b = instruction.fields.r.rt;

	assign program_counter_plus_four = instruction_program_counter + `MIPS_DATA_WIDTH'(4);

	////////////////////////////////////////////////////
	// control decoder.
	////////////////////////////////////////////////////

	// anything not listed stays all zero and moves down the pipe as a bubble.
	always_comb begin
		control = '0;
		if (instruction_valid) begin
			case (instruction.opcode)
				OP_RTYPE: begin
					case (instruction.fields.r.funct)
						FUNCT_ADDU, FUNCT_SUBU, FUNCT_AND, FUNCT_OR, FUNCT_SLT: begin
							control.register_write = 1'b1;
							control.register_destination = DEST_RD;
							control.alu_function = alu_function_t'(instruction.fields.r.funct);
						end
						FUNCT_MULT: begin
							control.hi_register_write = 1'b1;
							control.lo_register_write = 1'b1;
							control.alu_function = ALU_MULT;
						end
						FUNCT_MFHI, FUNCT_MFLO: begin
							control.register_write = 1'b1;
							control.register_destination = DEST_RD;
							control.using_hi_lo = 1'b1;
							control.alu_function = alu_function_t'(instruction.fields.r.funct);
						end
						default: control = '0;
					endcase
				end
				OP_ADDIU: begin
					control.register_write = 1'b1;
					control.alu_src_b = SRC_B_SIGN_IMMEDIATE;
					control.alu_function = ALU_ADDU;
				end
				OP_SLTI: begin
					control.register_write = 1'b1;
					control.alu_src_b = SRC_B_SIGN_IMMEDIATE;
					control.alu_function = ALU_SLT;
				end
				OP_ORI: begin
					control.register_write = 1'b1;
					control.alu_src_b = SRC_B_ZERO_IMMEDIATE;
					control.alu_function = ALU_OR;
				end
				OP_SW: begin
					control.memory_write = 1'b1;
					control.alu_src_b = SRC_B_SIGN_IMMEDIATE;
					control.alu_function = ALU_ADDU;
				end
				OP_J: begin
					control.program_counter_multiplexer_jump = 1'b1;
					control.j_instruction = 1'b1;
				end
				OP_JAL: begin
					control.program_counter_multiplexer_jump = 1'b1;
					control.j_instruction = 1'b1;
					control.register_write = 1'b1;
					control.register_destination = DEST_RA;
				end
				default: control = '0;
			endcase
		end
	end

	always_comb begin
		decoded.control = control;
		decoded.rs = instruction.fields.r.rs;
		decoded.rt = instruction.fields.r.rt;
		decoded.rd = instruction.fields.r.rd;
		decoded.sign_imm = {{16{instruction.fields.i.immediate[15]}},
			instruction.fields.i.immediate};
		decoded.src_a = read_data_a;
		decoded.src_b = read_data_b;
		decoded.program_counter_plus_four = program_counter_plus_four;
		// pseudo-direct target within the current 256 MB region.
		decoded.j_program_counter = {program_counter_plus_four[31:28],
			instruction.fields.index, 2'b00};
	end

endmodule

`default_nettype wire

//--- source/stage_register.sv
`timescale 1ns/10ps
`default_nettype none

module stage_register #(
	parameter type payload_t = logic
) (
	input  logic clk,
	input  logic reset,
	input  logic clear,
	input  payload_t d,
	output payload_t q
);

	// an all-zero payload carries no strobes, so clear turns the slot into a bubble.
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			q <= '0;
		end else if (clear) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module execute_stage (
	input  logic clk,
	input  logic reset,
	input  mips_pipeline_pkg::decode_execute_t decoded,
	input  mips_pipeline_pkg::execute_writeback_t writeback,
	output mips_pipeline_pkg::execute_writeback_t result,
	output logic jump_taken,
	output logic [`MIPS_DATA_WIDTH-1:0] jump_target
);

	import mips_isa_pkg::*;
	import mips_pipeline_pkg::*;

	logic forward_a;
	logic forward_b;
	logic [`MIPS_DATA_WIDTH-1:0] operand_a;
	logic [`MIPS_DATA_WIDTH-1:0] register_b;
	logic [`MIPS_DATA_WIDTH-1:0] operand_b;
	logic [`MIPS_DATA_WIDTH-1:0] alu_value;
	logic [`MIPS_DATA_WIDTH-1:0] hi_register;
	logic [`MIPS_DATA_WIDTH-1:0] lo_register;
	logic signed [2*`MIPS_DATA_WIDTH-1:0] product;
	logic [`MIPS_REG_ADDR_WIDTH-1:0] destination;

	////////////////////////////////////////////////////
	// forwarding from the writeback register.
	////////////////////////////////////////////////////

	assign forward_a = writeback.register_write && (writeback.write_register != '0)
		&& (writeback.write_register == decoded.rs);
	assign forward_b = writeback.register_write && (writeback.write_register != '0)
		&& (writeback.write_register == decoded.rt);

	assign operand_a = forward_a ? writeback.result : decoded.src_a;
	assign register_b = forward_b ? writeback.result : decoded.src_b;

	always_comb begin
		case (decoded.control.alu_src_b)
			SRC_B_SIGN_IMMEDIATE: operand_b = decoded.sign_imm;
			SRC_B_ZERO_IMMEDIATE: operand_b = {16'b0, decoded.sign_imm[15:0]};
			default:              operand_b = register_b;
		endcase
	end

	always_comb begin
		alu_value = '0;
		if (decoded.control.using_hi_lo) begin
			alu_value = (decoded.control.alu_function == ALU_MFHI) ? hi_register : lo_register;
		end else begin
			case (decoded.control.alu_function)
				ALU_ADDU: alu_value = operand_a + operand_b;
				ALU_SUBU: alu_value = operand_a - operand_b;
				ALU_AND:  alu_value = operand_a & operand_b;
				ALU_OR:   alu_value = operand_a | operand_b;
				ALU_SLT:  alu_value[0] = $signed(operand_a) < $signed(operand_b);
				default:  alu_value = '0;
			endcase
		end
	end

	// the full signed product is split across hi and lo.
	assign product = $signed(operand_a) * $signed(operand_b);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			hi_register <= '0;
			lo_register <= '0;
		end else begin
			if (decoded.control.hi_register_write)
				hi_register <= product[2*`MIPS_DATA_WIDTH-1:`MIPS_DATA_WIDTH];
			if (decoded.control.lo_register_write)
				lo_register <= product[`MIPS_DATA_WIDTH-1:0];
		end
	end

	always_comb begin
		case (decoded.control.register_destination)
			DEST_RD: destination = decoded.rd;
			DEST_RA: destination = `MIPS_REG_ADDR_WIDTH'(31);
			default: destination = decoded.rt;
		endcase
	end

	// writes to register zero are dropped here so no strobe leaves the slice.
	always_comb begin
		result.register_write = decoded.control.register_write && (destination != '0);
		result.write_register = destination;
		result.result = (decoded.control.register_destination == DEST_RA)
			? decoded.program_counter_plus_four : alu_value;
		result.memory_write = decoded.control.memory_write;
		result.store_data = register_b;
		result.memory_address = alu_value;
	end

	assign jump_taken = decoded.control.program_counter_multiplexer_jump;
	assign jump_target = decoded.control.j_instruction ? decoded.j_program_counter : operand_a;

endmodule

`default_nettype wire

//--- source/mips_core_slice.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module mips_core_slice (
	input  logic clk,
	input  logic reset,
	input  mips_isa_pkg::instruction_t instruction,
	input  logic [`MIPS_DATA_WIDTH-1:0] instruction_program_counter,
	input  logic instruction_valid,
	output logic register_write,
	output logic [`MIPS_REG_ADDR_WIDTH-1:0] write_register,
	output logic [`MIPS_DATA_WIDTH-1:0] write_data,
	output logic memory_write,
	output logic [`MIPS_DATA_WIDTH-1:0] memory_address,
	output logic [`MIPS_DATA_WIDTH-1:0] store_data,
	output logic jump_taken,
	output logic [`MIPS_DATA_WIDTH-1:0] jump_target
);

	import mips_pipeline_pkg::*;

	logic [`MIPS_REG_ADDR_WIDTH-1:0] read_address_a;
	logic [`MIPS_REG_ADDR_WIDTH-1:0] read_address_b;
	logic [`MIPS_DATA_WIDTH-1:0] read_data_a;
	logic [`MIPS_DATA_WIDTH-1:0] read_data_b;
	decode_execute_t decoded;
	decode_execute_t decoded_execute;
	execute_writeback_t executed;
	execute_writeback_t writeback;

	decode_stage decode_stage_inst (
		.instruction, .instruction_program_counter, .instruction_valid,
		.read_address_a, .read_address_b, .read_data_a, .read_data_b,
		.decoded
	);

	// a jump in execute squashes the instruction now in decode.
	stage_register #(.payload_t(decode_execute_t)) decode_execute_register_inst (
		.clk, .reset, .clear(jump_taken), .d(decoded), .q(decoded_execute)
	);

	execute_stage execute_stage_inst (
		.clk, .reset, .decoded(decoded_execute), .writeback,
		.result(executed), .jump_taken, .jump_target
	);

	stage_register #(.payload_t(execute_writeback_t)) execute_writeback_register_inst (
		.clk, .reset, .clear(1'b0), .d(executed), .q(writeback)
	);

	register_file register_file_inst (
		.clk, .reset, .read_address_a, .read_address_b, .read_data_a, .read_data_b,
		.write_enable(writeback.register_write), .write_address(writeback.write_register),
		.write_data(writeback.result)
	);

	assign register_write = writeback.register_write;
	assign write_register = writeback.write_register;
	assign write_data = writeback.result;
	assign memory_write = writeback.memory_write;
	assign memory_address = writeback.memory_address;
	assign store_data = writeback.store_data;

endmodule

`default_nettype wire

//--- verification/mips_core_slice_assertions.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module mips_core_slice_assertions (
	input logic clk,
	input logic reset,
	input logic register_write,
	input logic [`MIPS_REG_ADDR_WIDTH-1:0] write_register,
	input logic memory_write,
	input logic jump_taken
);

	int failure_count = 0;

	// both stage registers clear asynchronously, so no strobe survives into a reset cycle.
	strobes_low_in_reset: assert property (@(posedge clk)
		reset |-> !register_write && !memory_write && !jump_taken)
	else begin
		failure_count++;
		$error("a strobe is high while reset is asserted");
	end

	no_write_to_zero: assert property (@(posedge clk) disable iff (reset)
		register_write |-> write_register != '0)
	else begin
		failure_count++;
		$error("register zero is written");
	end

	// the jump squashes the slot behind it, so a second jump cycle cannot follow.
	single_cycle_jump: assert property (@(posedge clk) disable iff (reset)
		jump_taken |=> !jump_taken)
	else begin
		failure_count++;
		$error("jump_taken stays high for two cycles");
	end

endmodule

`default_nettype wire

//--- verification/mips_core_slice_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_macros.svh"

module mips_core_slice_tb;

	import mips_isa_pkg::*;

	typedef struct packed {
		int due;
		logic register_write;
		logic [`MIPS_REG_ADDR_WIDTH-1:0] write_register;
		logic [`MIPS_DATA_WIDTH-1:0] write_data;
		logic memory_write;
		logic [`MIPS_DATA_WIDTH-1:0] memory_address;
		logic [`MIPS_DATA_WIDTH-1:0] store_data;
	} outcome_t;

	typedef struct packed {
		int due;
		logic [`MIPS_DATA_WIDTH-1:0] target;
	} redirect_t;

	logic clk;
	logic reset;
	instruction_t instruction;
	logic [`MIPS_DATA_WIDTH-1:0] instruction_program_counter;
	logic instruction_valid;
	logic register_write;
	logic [`MIPS_REG_ADDR_WIDTH-1:0] write_register;
	logic [`MIPS_DATA_WIDTH-1:0] write_data;
	logic memory_write;
	logic [`MIPS_DATA_WIDTH-1:0] memory_address;
	logic [`MIPS_DATA_WIDTH-1:0] store_data;
	logic jump_taken;
	logic [`MIPS_DATA_WIDTH-1:0] jump_target;

	outcome_t outcomes[$];
	redirect_t redirects[$];
	logic [`MIPS_DATA_WIDTH-1:0] model_registers [`MIPS_REG_COUNT];
	logic [`MIPS_DATA_WIDTH-1:0] model_hi;
	logic [`MIPS_DATA_WIDTH-1:0] model_lo;
	logic [`MIPS_DATA_WIDTH-1:0] next_pc;
	logic jump_pending;
	integer seed;
	int cycle;
	int errors;
	int assertion_failures;
	string test_name;

	mips_core_slice mips_core_slice_inst (.*);

	bind mips_core_slice mips_core_slice_assertions assertions_inst (.*);

	always #20 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	always @(negedge clk) begin
		if (!reset)
			check_outputs();
	end

	function automatic logic [31:0] r_word(funct_t funct, int rd, int rs, int rt);
		return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'b0, funct};
	endfunction

	function automatic logic [31:0] i_word(opcode_t opcode, int rt, int rs, logic [15:0] imm);
		return {opcode, 5'(rs), 5'(rt), imm};
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
	endtask

	task automatic clear_model();
		for (int i = 0; i < `MIPS_REG_COUNT; i++)
			model_registers[i] = '0;
		model_hi = '0;
		model_lo = '0;
		jump_pending = 1'b0;
	endtask

	task automatic apply_reset();
		reset <= 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		clear_model();
	endtask

	////////////////////////////////////////////////////
	// fetch model and reference registers.
	////////////////////////////////////////////////////

	// the instruction right behind a jump is squashed, so it never reaches the model.
	task automatic issue(input logic [31:0] word);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] value;
		logic [4:0] destination;
		logic writes;
		logic signed [63:0] product;
		outcome_t expected;
		redirect_t redirect;
		@(posedge clk);
		instruction <= instruction_t'(word);
		instruction_program_counter <= next_pc;
		instruction_valid <= 1'b1;
		if (jump_pending) begin
			jump_pending = 1'b0;
		end else begin
			a = model_registers[word[25:21]];
			b = model_registers[word[20:16]];
			simm = {{16{word[15]}}, word[15:0]};
			destination = word[20:16];
			writes = 1'b1;
			value = '0;
			expected = '0;
			expected.due = cycle + 3;
			redirect.due = cycle + 2;
			redirect.target = {4'((next_pc + 32'd4) >> 28), word[25:0], 2'b00};
			case (word[31:26])
				OP_RTYPE: begin
					destination = word[15:11];
					case (word[5:0])
						FUNCT_ADDU: value = a + b;
						FUNCT_SUBU: value = a - b;
						FUNCT_AND:  value = a & b;
						FUNCT_OR:   value = a | b;
						FUNCT_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						FUNCT_MFHI: value = model_hi;
						FUNCT_MFLO: value = model_lo;
						default: begin
							product = $signed(a) * $signed(b);
							{model_hi, model_lo} = product;
							writes = 1'b0;
						end
					endcase
				end
				OP_ADDIU: value = a + simm;
				OP_SLTI:  value = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
				OP_ORI:   value = a | {16'b0, word[15:0]};
				OP_SW: begin
					writes = 1'b0;
					expected.memory_write = 1'b1;
					expected.memory_address = a + simm;
					expected.store_data = b;
				end
				default: begin
					// a jal links the address after itself.
					redirects.push_back(redirect);
					jump_pending = 1'b1;
					writes = (word[31:26] == OP_JAL);
					destination = 5'd31;
					value = next_pc + 32'd4;
				end
			endcase
			if (writes && destination != '0) begin
				expected.register_write = 1'b1;
				expected.write_register = destination;
				expected.write_data = value;
				model_registers[destination] = value;
			end
			if (expected.register_write || expected.memory_write)
				outcomes.push_back(expected);
		end
		next_pc = next_pc + 32'd4;
	endtask

	// a bubble still carries an instruction word, which valid low must hide.
	task automatic idle();
		@(posedge clk);
		instruction <= instruction_t'(r_word(FUNCT_ADDU, 1, 2, 3));
		instruction_valid <= 1'b0;
		jump_pending = 1'b0;
		next_pc = next_pc + 32'd4;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		idle();
		while ((outcomes.size() > 0 || redirects.size() > 0) && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (outcomes.size() > 0 || redirects.size() > 0) begin
			$display("timeout: results of test %s never left the pipeline", test_name);
			$display("Simulation failed");
			$finish;
		end
	endtask

	task automatic check_outputs();
		outcome_t expected;
		redirect_t redirect;
		logic jump_expected;
		expected = '0;
		redirect = '0;
		jump_expected = 1'b0;
		if (outcomes.size() > 0 && outcomes[0].due == cycle)
			expected = outcomes.pop_front();
		if (redirects.size() > 0 && redirects[0].due == cycle) begin
			redirect = redirects.pop_front();
			jump_expected = 1'b1;
		end
		assert (register_write === expected.register_write)
			else report_mismatch("register_write", expected.register_write, register_write);
		if (expected.register_write) begin
			assert (write_register === expected.write_register)
				else report_mismatch("write_register", expected.write_register, write_register);
			assert (write_data === expected.write_data)
				else report_mismatch("write_data", expected.write_data, write_data);
		end
		assert (memory_write === expected.memory_write)
			else report_mismatch("memory_write", expected.memory_write, memory_write);
		if (expected.memory_write) begin
			assert (memory_address === expected.memory_address)
				else report_mismatch("memory_address", expected.memory_address, memory_address);
			assert (store_data === expected.store_data)
				else report_mismatch("store_data", expected.store_data, store_data);
		end
		assert (jump_taken === jump_expected)
			else report_mismatch("jump_taken", jump_expected, jump_taken);
		if (jump_expected) begin
			assert (jump_target === redirect.target)
				else report_mismatch("jump_target", redirect.target, jump_target);
		end
	endtask

	////////////////////////////////////////////////////
	// directed tests.
	////////////////////////////////////////////////////

	task automatic alu_operations();
		test_name = "alu_ops";
		for (int i = 0; i < 8; i++) begin
			issue(i_word(OP_ADDIU, 1, 0, 16'($random(seed))));
			issue(i_word(OP_ADDIU, 2, 0, 16'($random(seed))));
			issue(r_word(FUNCT_MULT, 0, 1, 2));
			issue(r_word(FUNCT_MFLO, 3, 0, 0));
			issue(r_word(FUNCT_ADDU, 4, 3, 1));
			issue(r_word(FUNCT_SUBU, 5, 1, 3));
			issue(r_word(FUNCT_AND, 6, 3, 2));
			issue(r_word(FUNCT_OR, 7, 2, 3));
			issue(r_word(FUNCT_SLT, 8, 1, 3));
			issue(i_word(OP_ADDIU, 9, 3, 16'($random(seed))));
			issue(i_word(OP_SLTI, 10, 3, 16'($random(seed))));
			issue(i_word(OP_ORI, 11, 3, 16'($random(seed))));
		end
		drain();
	endtask

	task automatic operand_dependencies();
		test_name = "dependencies";
		issue(i_word(OP_ADDIU, 12, 0, 16'd5));
		issue(i_word(OP_ADDIU, 13, 0, 16'hfff9));
		// r13 comes from forwarding and r12 through the register file bypass.
		issue(r_word(FUNCT_SUBU, 14, 12, 13));
		issue(i_word(OP_ADDIU, 0, 14, 16'd99));
		issue(r_word(FUNCT_OR, 15, 0, 14));
		issue(r_word(FUNCT_ADDU, 16, 15, 15));
		drain();
	endtask

	task automatic hi_lo_moves();
		test_name = "hi_lo";
		issue(i_word(OP_ADDIU, 17, 0, 16'hfed4));
		issue(i_word(OP_ADDIU, 18, 0, 16'd12345));
		issue(r_word(FUNCT_MULT, 0, 17, 18));
		issue(r_word(FUNCT_MFHI, 19, 0, 0));
		issue(r_word(FUNCT_MFLO, 20, 0, 0));
		drain();
	endtask

	task automatic word_stores();
		test_name = "store";
		issue(i_word(OP_ADDIU, 21, 0, 16'h0100));
		issue(i_word(OP_ORI, 22, 0, 16'($random(seed))));
		issue(i_word(OP_SW, 22, 21, 16'hfff8));
		idle();
		issue(i_word(OP_SW, 21, 22, 16'h0010));
		drain();
	endtask

	task automatic jump_redirects();
		test_name = "jumps";
		next_pc = 32'h9040_0010;
		issue({OP_J, 26'h012_3456});
		issue(i_word(OP_ADDIU, 23, 0, 16'd1));
		issue({OP_JAL, 26'h3ff_fffc});
		issue(r_word(FUNCT_ADDU, 24, 0, 21));
		issue(r_word(FUNCT_OR, 25, 31, 0));
		issue(r_word(FUNCT_ADDU, 26, 23, 24));
		drain();
	endtask

	task automatic reset_clearing();
		test_name = "reset";
		repeat (3) idle();
		apply_reset();
		issue(r_word(FUNCT_OR, 27, 3, 31));
		issue(r_word(FUNCT_ADDU, 28, 14, 22));
		issue(r_word(FUNCT_MFHI, 29, 0, 0));
		drain();
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instruction = '0;
		instruction_program_counter = '0;
		instruction_valid = 1'b0;
		cycle = 0;
		errors = 0;
		seed = 32'hf8f4_8c63;
		next_pc = 32'h0040_0000;
		test_name = "startup";
		apply_reset();
		alu_operations();
		operand_dependencies();
		hi_lo_moves();
		word_stores();
		jump_redirects();
		reset_clearing();
		assertion_failures = mips_core_slice_inst.assertions_inst.failure_count;
		$display("check errors: %0d, assertion failures: %0d", errors, assertion_failures);
		if (errors == 0 && assertion_failures == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
source/mips_isa_pkg.sv
source/mips_pipeline_pkg.sv
source/register_file.sv
source/decode_stage.sv
source/stage_register.sv
source/execute_stage.sv
source/mips_core_slice.sv
verification/mips_core_slice_assertions.sv
verification/mips_core_slice_tb.sv

//--- Bender.yml
package:
  name: mips_core_slice

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/mips_isa_pkg.sv
      - source/mips_pipeline_pkg.sv
      - source/register_file.sv
      - source/decode_stage.sv
      - source/stage_register.sv
      - source/execute_stage.sv
      - source/mips_core_slice.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/mips_core_slice_assertions.sv
      - verification/mips_core_slice_tb.sv
